//--- verilog.f
rtl/core_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/context_manager.sv
rtl/inst_window.sv
rtl/frontend_top.sv
tests/frontend_properties.sv
tests/frontend_tb.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module frontend_tb \
		-f verilog.f -Mdir obj_dir

run: build
	./obj_dir/Vfrontend_tb 2>&1 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing --top-module frontend_tb -f verilog.f

clean:
	rm -rf obj_dir sim.log

//--- tests/frontend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_tb
    import core_pkg::*;
();

    localparam int TAKE_COUNT  = 3000;
    localparam int CYCLE_LIMIT = TAKE_COUNT * 4;

    logic       clk;
    logic       rst;
    inst_t      instr;
    word_t      imem_addr;
    logic       resolve;
    logic       resolve_taken;
    logic       jump_target;
    word_t      jump_pc;
    logic       take;
    logic       head_valid;
    exec_type_t head_exec_type;
    vreg_t      head_va_rs1;
    vreg_t      head_va_rs2;
    vreg_t      head_va_rd;
    word_t      head_imm;
    func3_t     head_func3;
    func7_t     head_func7;
    logic       head_io_type;
    ctx_t       head_ctx;
    ctx_t       head_ctx_b_t;
    ctx_t       head_ctx_b_f;

    inst_t       prog [64];
    opecode_t    op_list [14];
    logic [15:0] lfsr;
    int          cycles;
    int          taken;
    // Reference model state, advanced in program order at each take
    word_t       m_pc;
    ctx_t        m_ctx;
    logic        m_pred;
    word_t       m_alt_pc;
    ctx_t        m_alt_ctx;
    logic        pending_res;
    logic        pending_jump;
    logic        fetch_redirect;

    frontend_top u_dut (.*);

    assign instr = prog[imem_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic fail_stop();
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_vreg(input string name, input vreg_t exp, input vreg_t act);
        if (exp !== act) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_exec(input string name, input exec_type_t exp, input exec_type_t act);
        if (exp !== act) begin
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_ctx(input string name, input ctx_t exp, input ctx_t act);
        if (exp !== act) begin
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
            fail_stop();
        end
    endtask

    // Lowest free bit for taken, next one for fall-through
    task automatic alloc_ctx(input ctx_t cur, output ctx_t ct, output ctx_t cf);
        int n;
        n  = 0;
        ct = '0;
        cf = '0;
        for (int i = 0; i < 4; i++) begin
            if (!cur[i]) begin
                if (n == 0) ct[i] = 1'b1;
                if (n == 1) cf[i] = 1'b1;
                n++;
            end
        end
    endtask

    task automatic expect_fields(input inst_t ins, input word_t pc, output exec_type_t ex,
                                 output vreg_t rs1, output vreg_t rs2, output vreg_t rd,
                                 output word_t imm, output func3_t f3, output func7_t f7,
                                 output logic io);
        word_t imm_i;
        word_t imm_s;
        word_t imm_u;
        logic  sel;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_u = {ins[31:12], 12'b0};
        ex  = '0;
        rs1 = '0;
        rs2 = '0;
        rd  = '0;
        imm = '0;
        f3  = ins[14:12];
        f7  = '0;
        io  = 1'b0;
        case (ins[6:0])
            OP_ALU: begin
                ex[ins[25] ? EX_ALU_EXT : EX_ALU] = 1'b1;
                f7  = ins[31:25];
                rs1 = {1'b0, ins[19:15]};
                rs2 = {1'b0, ins[24:20]};
                rd  = {1'b0, ins[11:7]};
            end
            OP_ALUI: begin
                ex[EX_ALU] = 1'b1;
                f7  = (f3[1:0] == 2'b01) ? ins[31:25] : '0;
                rs1 = {1'b0, ins[19:15]};
                rd  = {1'b0, ins[11:7]};
                imm = imm_i;
            end
            OP_FPU: begin
                ex[EX_FPU] = 1'b1;
                f7  = ins[31:25];
                sel = f7[3] ^ f7[4];
                rs1 = {!f7[6] || sel, ins[19:15]};
                rd  = {!f7[6] || !sel, ins[11:7]};
                if (!f7[5]) rs2 = {1'b1, ins[24:20]};
            end
            OP_MEML, OP_FMEML: begin
                ex[EX_MEM] = 1'b1;
                rs1 = {1'b0, ins[19:15]};
                rd  = {ins[2], ins[11:7]};
                imm = imm_i;
            end
            OP_MEMS, OP_FMEMS: begin
                ex[EX_MEM] = 1'b1;
                rs1 = {1'b0, ins[19:15]};
                rs2 = {ins[2], ins[24:20]};
                imm = imm_s;
                io  = 1'b1;
            end
            OP_JAL, OP_AUIPC, OP_LUI: begin
                ex[EX_SUBST] = 1'b1;
                rd  = {1'b0, ins[11:7]};
                if (ins[6:0] != OP_LUI) f3 = '0;
                imm = (ins[6:0] == OP_JAL) ? pc + 32'd4
                    : (ins[6:0] == OP_AUIPC) ? imm_u + pc : imm_u;
            end
            OP_JALR: begin
                ex[EX_JUMP] = 1'b1;
                rs1 = {1'b0, ins[19:15]};
                rd  = {1'b0, ins[11:7]};
                imm = imm_i;
            end
            OP_BRANCH: begin
                ex[EX_BRANCH] = 1'b1;
                rs1 = {1'b0, ins[19:15]};
                rs2 = {1'b0, ins[24:20]};
            end
            OP_INPUT: begin
                ex[EX_IO] = 1'b1;
                f7 = ins[31:25];
                rd = {f7[5], ins[11:7]};
            end
            default: begin
                ex[EX_IO] = 1'b1;
                f7  = ins[31:25];
                rs1 = {f7[5], ins[19:15]};
                io  = 1'b1;
            end
        endcase
    endtask

    // Compare the head with the model and step the model's program order
    task automatic take_head();
        inst_t      ins;
        exec_type_t ex;
        vreg_t      rs1;
        vreg_t      rs2;
        vreg_t      rd;
        word_t      imm;
        func3_t     f3;
        func7_t     f7;
        logic       io;
        ctx_t       ct;
        ctx_t       cf;
        word_t      off;
        ins = prog[m_pc[7:2]];
        expect_fields(ins, m_pc, ex, rs1, rs2, rd, imm, f3, f7, io);
        alloc_ctx(m_ctx, ct, cf);
        check_exec("head_exec_type", ex, head_exec_type);
        check_vreg("head_va_rs1", rs1, head_va_rs1);
        check_vreg("head_va_rs2", rs2, head_va_rs2);
        check_vreg("head_va_rd", rd, head_va_rd);
        check_word("head_imm", imm, head_imm);
        check_word("head_func3", word_t'(f3), word_t'(head_func3));
        check_word("head_func7", word_t'(f7), word_t'(head_func7));
        check_word("head_io_type", word_t'(io), word_t'(head_io_type));
        check_ctx("head_ctx", m_ctx, head_ctx);
        check_ctx("head_ctx_b_t", ct, head_ctx_b_t);
        check_ctx("head_ctx_b_f", cf, head_ctx_b_f);
        case (ins[6:0])
            OP_JAL: begin
                off  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                m_pc = m_pc + off;
            end
            OP_BRANCH: begin
                off         = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                m_pred      = off[31];
                m_alt_pc    = m_pred ? m_pc + 32'd4 : m_pc + off;
                m_alt_ctx   = m_pred ? cf : ct;
                m_pc        = m_pred ? m_pc + off : m_pc + 32'd4;
                m_ctx       = m_pred ? ct : cf;
                pending_res = 1'b1;
            end
            OP_JALR: pending_jump = 1'b1;
            default: m_pc = m_pc + 32'd4;
        endcase
    endtask

    initial begin
        logic [31:0] r;
        op_list = '{OP_ALU, OP_ALUI, OP_FPU, OP_MEML, OP_MEMS, OP_FMEML, OP_FMEMS,
                    OP_JAL, OP_JALR, OP_BRANCH, OP_LUI, OP_AUIPC, OP_INPUT, OP_OUTPUT};
        lfsr = 16'd2105;
        for (int i = 0; i < 64; i++) begin
            get_bits(4, r);
            prog[i][6:0] = op_list[r % 14];
            get_bits(25, r);
            prog[i][31:7] = r[24:0];
        end
        rst            = 1'b1;
        resolve        = 1'b0;
        resolve_taken  = 1'b0;
        jump_target    = 1'b0;
        jump_pc        = '0;
        take           = 1'b0;
        m_pc           = '0;
        m_ctx          = CTX_RESET;
        m_pred         = 1'b0;
        m_alt_pc       = '0;
        m_alt_ctx      = '0;
        pending_res    = 1'b0;
        pending_jump   = 1'b0;
        fetch_redirect = 1'b0;
        cycles         = 0;
        taken          = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (taken < TAKE_COUNT && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
            cycles++;
            // Fetch sits on the model's PC after a redirect and while a JALR waits
            if (fetch_redirect || pending_jump) begin
                check_word("imem_addr", m_pc, imem_addr);
            end
            fetch_redirect = 1'b0;
            resolve        = 1'b0;
            jump_target    = 1'b0;
            take           = 1'b0;
            get_bits(1, r);
            if (pending_res && r[0]) begin
                get_bits(1, r);
                resolve       = 1'b1;
                resolve_taken = r[0];
                pending_res   = 1'b0;
                if (r[0] != m_pred) begin
                    m_pc           = m_alt_pc;
                    m_ctx          = m_alt_ctx;
                    fetch_redirect = 1'b1;
                end
            end else if (pending_jump && r[0]) begin
                get_bits(6, r);
                jump_target    = 1'b1;
                jump_pc        = {24'b0, r[5:0], 2'b00};
                m_pc           = jump_pc;
                pending_jump   = 1'b0;
                fetch_redirect = 1'b1;
            end else if (!pending_res && !pending_jump && head_valid && r[0]) begin
                take = 1'b1;
                take_head();
                taken++;
            end
        end
        if (taken == TAKE_COUNT) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Timeout after %0d cycles with %0d entries taken", cycles, taken);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

//--- tests/frontend_properties.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_properties
    import core_pkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire logic branch_hazard,
    input wire logic load,
    input wire ctx_t load_ctx,
    input wire logic wr,
    input wire logic full
);

    // Hazard is a single-cycle strobe
    a_hazard_one_cycle: assert property (@(posedge clk) disable iff (rst)
        branch_hazard |=> !branch_hazard)
        else $error("branch_hazard held for more than one cycle");

    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        !(wr && full))
        else $error("window written while full");

    a_load_ctx_onehot: assert property (@(posedge clk) disable iff (rst)
        load |-> $onehot(load_ctx))
        else $error("load_ctx is not one-hot");

endmodule

bind context_manager frontend_properties u_cm_props (
    .clk           (clk),
    .rst           (rst),
    .branch_hazard (branch_hazard),
    .load          (load),
    .load_ctx      (load_ctx),
    .wr            (1'b0),
    .full          (1'b0)
);

bind inst_window frontend_properties u_win_props (
    .clk           (clk),
    .rst           (rst),
    .branch_hazard (branch_hazard),
    .load          (1'b0),
    .load_ctx      (CTX_RESET),
    .wr            (wr),
    .full          (full)
);

`default_nettype wire

//--- rtl/frontend_top.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_top
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  inst_t      instr,
    output word_t      imem_addr,
    input  logic       resolve,
    input  logic       resolve_taken,
    input  logic       jump_target,
    input  word_t      jump_pc,
    input  logic       take,
    output logic       head_valid,
    output exec_type_t head_exec_type,
    output vreg_t      head_va_rs1,
    output vreg_t      head_va_rs2,
    output vreg_t      head_va_rd,
    output word_t      head_imm,
    output func3_t     head_func3,
    output func7_t     head_func7,
    output logic       head_io_type,
    output ctx_t       head_ctx,
    output ctx_t       head_ctx_b_t,
    output ctx_t       head_ctx_b_f
);

    word_t      pc;
    ctx_t       ctx;
    logic       fetch_valid;
    logic       load;
    word_t      load_pc;
    ctx_t       load_ctx;
    logic       hold;
    logic       stop;
    logic       done;
    logic       next_pc_ready;
    logic       branch;
    logic       jalr;
    word_t      next_pc;
    word_t      next_pc_f;
    exec_type_t exec_type;
    vreg_t      va_rs1;
    vreg_t      va_rs2;
    vreg_t      va_rd;
    word_t      imm;
    func3_t     func3;
    func7_t     func7;
    logic       io_type;
    ctx_t       entry_ctx;
    ctx_t       ctx_b_t;
    ctx_t       ctx_b_f;
    logic       branch_hazard;
    ctx_t       hazard_context_info;
    ctx_t       context_b_t;
    ctx_t       context_b_f;
    logic       spec_busy;
    logic       decode_able;

    fetch u_fetch (.*);

    decode u_decode (
        .context_in (ctx),
        .*
    );

    context_manager u_context_manager (.*);

    // Decoded instructions enter the window on done
    inst_window u_inst_window (
        .wr (done),
        .*
    );

endmodule

`default_nettype wire

//--- rtl/inst_window.sv
`timescale 1ns/1ns
`default_nettype none

module inst_window
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wr,
    input  exec_type_t exec_type,
    input  vreg_t      va_rs1,
    input  vreg_t      va_rs2,
    input  vreg_t      va_rd,
    input  word_t      imm,
    input  func3_t     func3,
    input  func7_t     func7,
    input  logic       io_type,
    input  ctx_t       entry_ctx,
    input  ctx_t       ctx_b_t,
    input  ctx_t       ctx_b_f,
    input  logic       spec_busy,
    input  logic       branch,
    input  logic       branch_hazard,
    input  ctx_t       hazard_context_info,
    input  logic       take,
    output logic       decode_able,
    output logic       head_valid,
    output exec_type_t head_exec_type,
    output vreg_t      head_va_rs1,
    output vreg_t      head_va_rs2,
    output vreg_t      head_va_rd,
    output word_t      head_imm,
    output func3_t     head_func3,
    output func7_t     head_func7,
    output logic       head_io_type,
    output ctx_t       head_ctx,
    output ctx_t       head_ctx_b_t,
    output ctx_t       head_ctx_b_f
);

    exec_type_t              exec_mem  [WINDOW_DEPTH];
    vreg_t                   rs1_mem   [WINDOW_DEPTH];
    vreg_t                   rs2_mem   [WINDOW_DEPTH];
    vreg_t                   rd_mem    [WINDOW_DEPTH];
    word_t                   imm_mem   [WINDOW_DEPTH];
    func3_t                  func3_mem [WINDOW_DEPTH];
    func7_t                  func7_mem [WINDOW_DEPTH];
    logic                    io_mem    [WINDOW_DEPTH];
    ctx_t                    ctx_mem   [WINDOW_DEPTH];
    ctx_t                    ctx_t_mem [WINDOW_DEPTH];
    ctx_t                    ctx_f_mem [WINDOW_DEPTH];
    logic [WINDOW_DEPTH-1:0] valid_q;
    logic [WINDOW_DEPTH-1:0] spec_q;
    win_ptr_t                head_q;
    win_ptr_t                tail_q;
    win_cnt_t                count_q;
    logic                    full;
    logic                    pop;

    assign full        = (count_q == win_cnt_t'(WINDOW_DEPTH));
    assign decode_able = !full && !(branch && spec_busy);
    assign head_valid  = (count_q != '0) && valid_q[head_q];
    // Flushed slots drain at the head without a take
    assign pop         = (count_q != '0) && (take || !valid_q[head_q]);

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
            spec_q  <= '0;
        end else begin
            for (int i = 0; i < WINDOW_DEPTH; i++) begin
                // Only entries younger than the open branch can be flushed
                if (branch_hazard && spec_q[i] && |(ctx_mem[i] & hazard_context_info)) begin
                    valid_q[i] <= 1'b0;
                end
                if (!spec_busy) begin
                    spec_q[i] <= 1'b0;
                end
            end
            if (wr) begin
                valid_q[tail_q] <= 1'b1;
                spec_q[tail_q]  <= spec_busy;
                tail_q          <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + win_cnt_t'(wr) - win_cnt_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            exec_mem[tail_q]  <= exec_type;
            rs1_mem[tail_q]   <= va_rs1;
            rs2_mem[tail_q]   <= va_rs2;
            rd_mem[tail_q]    <= va_rd;
            imm_mem[tail_q]   <= imm;
            func3_mem[tail_q] <= func3;
            func7_mem[tail_q] <= func7;
            io_mem[tail_q]    <= io_type;
            ctx_mem[tail_q]   <= entry_ctx;
            ctx_t_mem[tail_q] <= ctx_b_t;
            ctx_f_mem[tail_q] <= ctx_b_f;
        end
    end

    assign head_exec_type = exec_mem[head_q];
    assign head_va_rs1    = rs1_mem[head_q];
    assign head_va_rs2    = rs2_mem[head_q];
    assign head_va_rd     = rd_mem[head_q];
    assign head_imm       = imm_mem[head_q];
    assign head_func3     = func3_mem[head_q];
    assign head_func7     = func7_mem[head_q];
    assign head_io_type   = io_mem[head_q];
    assign head_ctx       = ctx_mem[head_q];
    assign head_ctx_b_t   = ctx_t_mem[head_q];
    assign head_ctx_b_f   = ctx_f_mem[head_q];

endmodule

`default_nettype wire

//--- rtl/context_manager.sv
`timescale 1ns/1ns
`default_nettype none

module context_manager
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  done,
    input  logic  next_pc_ready,
    input  logic  branch,
    input  logic  jalr,
    input  word_t next_pc,
    input  word_t next_pc_f,
    input  ctx_t  ctx,
    input  logic  resolve,
    input  logic  resolve_taken,
    input  logic  jump_target,
    input  word_t jump_pc,
    output logic  load,
    output word_t load_pc,
    output ctx_t  load_ctx,
    output logic  stop,
    output logic  hold,
    output logic  branch_hazard,
    output ctx_t  hazard_context_info,
    output ctx_t  context_b_t,
    output ctx_t  context_b_f,
    output logic  spec_busy
);

    cm_state_t state_q;
    logic      jump_spec_q;
    logic      pred_taken_q;
    ctx_t      pred_ctx_q;
    word_t     alt_pc_q;
    ctx_t      alt_ctx_q;
    ctx_t      free_ctx;
    ctx_t      rest_ctx;
    word_t     offset;
    logic      predict_taken;
    logic      mispredict;
    logic      commit;

    // Lowest two bits other than the current context
    assign free_ctx    = ~ctx;
    assign context_b_t = free_ctx & (~free_ctx + ctx_t'(1));
    assign rest_ctx    = free_ctx & ~context_b_t;
    assign context_b_f = rest_ctx & (~rest_ctx + ctx_t'(1));

    // Backward branches predicted taken
    assign offset        = next_pc - next_pc_f + 32'd4;
    assign predict_taken = offset[31];

    assign spec_busy  = (state_q == CM_SPEC) || (state_q == CM_WAIT_JUMP && jump_spec_q);
    assign mispredict = resolve && spec_busy && (resolve_taken != pred_taken_q);
    assign commit     = resolve && spec_busy && !mispredict;

    assign branch_hazard       = mispredict;
    assign hazard_context_info = mispredict ? pred_ctx_q : '0;

    assign stop = done && jalr;
    assign hold = !(done && next_pc_ready);

    always_comb begin
        load     = 1'b0;
        load_pc  = next_pc;
        load_ctx = ctx;
        if (mispredict) begin
            load     = 1'b1;
            load_pc  = alt_pc_q;
            load_ctx = alt_ctx_q;
        end else if (state_q == CM_WAIT_JUMP && jump_target) begin
            load    = 1'b1;
            load_pc = jump_pc;
        end else if (done && branch) begin
            load     = 1'b1;
            load_pc  = predict_taken ? next_pc : next_pc_f;
            load_ctx = predict_taken ? context_b_t : context_b_f;
        end else if (done && next_pc_ready && next_pc != next_pc_f) begin
            // JAL
            load = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= CM_RUN;
            jump_spec_q <= 1'b0;
        end else if (mispredict) begin
            // A pending JALR was on the wrong path
            state_q <= CM_RUN;
        end else begin
            case (state_q)
                CM_RUN: begin
                    if (done && jalr) begin
                        state_q     <= CM_WAIT_JUMP;
                        jump_spec_q <= 1'b0;
                    end else if (done && branch) begin
                        state_q <= CM_SPEC;
                    end
                end
                CM_SPEC: begin
                    if (done && jalr) begin
                        state_q     <= CM_WAIT_JUMP;
                        jump_spec_q <= !commit;
                    end else if (commit) begin
                        state_q <= CM_RUN;
                    end
                end
                default: begin
                    if (commit) begin
                        jump_spec_q <= 1'b0;
                    end
                    if (jump_target) begin
                        state_q <= (jump_spec_q && !commit) ? CM_SPEC : CM_RUN;
                    end
                end
            endcase
        end
    end

    // Path not followed, restored on a misprediction
    always_ff @(posedge clk) begin
        if (done && branch) begin
            pred_taken_q <= predict_taken;
            pred_ctx_q   <= predict_taken ? context_b_t : context_b_f;
            alt_pc_q     <= predict_taken ? next_pc_f : next_pc;
            alt_ctx_q    <= predict_taken ? context_b_f : context_b_t;
        end
    end

endmodule

`default_nettype wire

//--- rtl/decode.sv
`timescale 1ns/1ns
`default_nettype none

module decode
    import core_pkg::*;
(
    input  logic       fetch_valid,
    input  inst_t      instr,
    input  word_t      pc,
    input  ctx_t       context_in,
    input  logic       branch_hazard,
    input  ctx_t       hazard_context_info,
    input  ctx_t       context_b_t,
    input  ctx_t       context_b_f,
    input  logic       decode_able,
    output logic       done,
    output logic       next_pc_ready,
    output logic       branch,
    output logic       jalr,
    output word_t      next_pc,
    output word_t      next_pc_f,
    output exec_type_t exec_type,
    output vreg_t      va_rs1,
    output vreg_t      va_rs2,
    output vreg_t      va_rd,
    output word_t      imm,
    output func3_t     func3,
    output func7_t     func7,
    output logic       io_type,
    output ctx_t       entry_ctx,
    output ctx_t       ctx_b_t,
    output ctx_t       ctx_b_f
);

    opecode_t opecode;
    logic     alu;
    logic     alu_imm;
    logic     alu_ext;
    logic     fpu;
    logic     mem;
    logic     subst;
    logic     io;
    logic     float_op;
    logic     rs1_float;
    logic     rd_float;
    logic     no_use_rd;
    logic     no_use_rs1;
    logic     no_use_rs2;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_b;
    word_t    imm_j;
    word_t    imm_u;

    assign opecode = instr[6:0];

    // Instruction classes
    assign alu     = (opecode == OP_ALU) || (opecode == OP_ALUI);
    assign alu_imm = (opecode == OP_ALUI);
    assign alu_ext = (opecode == OP_ALU) && instr[25];
    assign fpu     = (opecode == OP_FPU);
    assign mem     = (opecode == OP_MEML) || (opecode == OP_MEMS)
                  || (opecode == OP_FMEML) || (opecode == OP_FMEMS);
    assign jalr    = (opecode == OP_JALR);
    assign branch  = (opecode == OP_BRANCH);
    assign subst   = (opecode == OP_LUI) || (opecode == OP_JAL) || (opecode == OP_AUIPC);
    assign io      = (opecode == OP_INPUT) || (opecode == OP_OUTPUT);

    assign func3 = ((opecode == OP_JAL) || (opecode == OP_AUIPC)) ? '0 : instr[14:12];

    // Shift immediates keep func7 as the shift kind
    assign func7 = (mem || jalr || branch || subst || (alu_imm && func3[1:0] != 2'b01))
                 ? '0 : instr[31:25];

    // Float register file selection
    assign float_op  = fpu || (opecode == OP_FMEML) || (opecode == OP_FMEMS)
                    || (io && func7[5]);
    assign rs1_float = float_op && !mem && (!func7[6] || (func7[3] ^ func7[4]) || io);
    assign rd_float  = float_op && (!func7[6] || !(func7[3] ^ func7[4]) || io);

    assign no_use_rd  = (opecode == OP_MEMS) || (opecode == OP_FMEMS)
                     || (opecode == OP_OUTPUT) || branch;
    assign no_use_rs1 = subst || (opecode == OP_INPUT);
    assign no_use_rs2 = !((opecode == OP_ALU) || branch || (opecode == OP_MEMS)
                       || (opecode == OP_FMEMS) || (fpu && !func7[5]));

    assign va_rd  = no_use_rd  ? '0 : {rd_float, instr[11:7]};
    assign va_rs1 = no_use_rs1 ? '0 : {rs1_float, instr[19:15]};
    assign va_rs2 = no_use_rs2 ? '0 : {float_op, instr[24:20]};

    // I, S, B, J and U immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        case (opecode)
            OP_ALUI, OP_MEML, OP_FMEML, OP_JALR: imm = imm_i;
            OP_MEMS, OP_FMEMS:                   imm = imm_s;
            // Link value for JAL
            OP_JAL:                              imm = next_pc_f;
            OP_LUI:                              imm = imm_u;
            OP_AUIPC:                            imm = imm_u + pc;
            default:                             imm = '0;
        endcase
    end

    always_comb begin
        exec_type             = '0;
        exec_type[EX_ALU]     = alu && !alu_ext;
        exec_type[EX_ALU_EXT] = alu_ext;
        exec_type[EX_FPU]     = fpu;
        exec_type[EX_MEM]     = mem;
        exec_type[EX_JUMP]    = jalr;
        exec_type[EX_BRANCH]  = branch;
        exec_type[EX_SUBST]   = subst;
        exec_type[EX_IO]      = io;
    end

    assign io_type = (io || mem) && opecode[5];

    // Wrong-path instructions are dropped in the hazard cycle
    assign done = fetch_valid && decode_able
               && !(branch_hazard && |(context_in & hazard_context_info));

    assign entry_ctx = context_in;
    assign ctx_b_t   = context_b_t;
    assign ctx_b_f   = context_b_f;

    assign next_pc_ready = done && (alu || fpu || mem || subst || io);
    assign next_pc_f     = pc + 32'd4;
    assign next_pc       = (opecode == OP_JAL) ? pc + imm_j
                         : branch              ? pc + imm_b
                         :                       next_pc_f;

endmodule

`default_nettype wire

//--- rtl/fetch.sv
`timescale 1ns/1ns
`default_nettype none

module fetch
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  load,
    input  word_t load_pc,
    input  ctx_t  load_ctx,
    input  logic  hold,
    input  logic  stop,
    output word_t pc,
    output ctx_t  ctx,
    output logic  fetch_valid,
    output word_t imem_addr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            ctx         <= CTX_RESET;
            fetch_valid <= 1'b1;
        end else if (load) begin
            // Redirect also resumes fetch after a JALR
            pc          <= load_pc;
            ctx         <= load_ctx;
            fetch_valid <= 1'b1;
        end else begin
            if (!hold) begin
                pc <= pc + 32'd4;
            end
            if (stop) begin
                fetch_valid <= 1'b0;
            end
        end
    end

    // Combinational instruction memory read
    assign imem_addr = pc;

endmodule

`default_nettype wire

//--- rtl/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    // One-hot speculation context
    typedef logic [3:0]  ctx_t;
    typedef logic [6:0]  opecode_t;
    typedef logic [2:0]  func3_t;
    typedef logic [6:0]  func7_t;
    // Bit 5 selects the float file, zero means unused
    typedef logic [5:0]  vreg_t;
    typedef logic [7:0]  exec_type_t;

    // RV32 encodings, custom space for FPU and I/O
    localparam opecode_t OP_ALU    = 7'b0110011;
    localparam opecode_t OP_ALUI   = 7'b0010011;
    localparam opecode_t OP_FPU    = 7'b1010011;
    localparam opecode_t OP_MEML   = 7'b0000011;
    localparam opecode_t OP_MEMS   = 7'b0100011;
    localparam opecode_t OP_FMEML  = 7'b0000111;
    localparam opecode_t OP_FMEMS  = 7'b0100111;
    localparam opecode_t OP_JAL    = 7'b1101111;
    localparam opecode_t OP_JALR   = 7'b1100111;
    localparam opecode_t OP_BRANCH = 7'b1100011;
    localparam opecode_t OP_LUI    = 7'b0110111;
    localparam opecode_t OP_AUIPC  = 7'b0010111;
    localparam opecode_t OP_INPUT  = 7'b0001011;
    localparam opecode_t OP_OUTPUT = 7'b0101011;

    // Bit positions in exec_type_t
    localparam int EX_ALU     = 0;
    localparam int EX_ALU_EXT = 1;
    localparam int EX_FPU     = 2;
    localparam int EX_MEM     = 3;
    localparam int EX_JUMP    = 4;
    localparam int EX_BRANCH  = 5;
    localparam int EX_SUBST   = 6;
    localparam int EX_IO      = 7;

    localparam int   WINDOW_DEPTH = 4;
    localparam ctx_t CTX_RESET    = 4'b0001;

    typedef logic [$clog2(WINDOW_DEPTH)-1:0]   win_ptr_t;
    typedef logic [$clog2(WINDOW_DEPTH+1)-1:0] win_cnt_t;

    typedef enum logic [1:0] {
        CM_RUN,
        CM_SPEC,
        CM_WAIT_JUMP
    } cm_state_t;

endpackage

`default_nettype wire
